// File: build.f
+incdir+source
source/sa_pkg.sv
source/sa_pe.sv
source/sa_array.sv
source/sa_shared_buffer.sv
source/sa_apb_port.sv
source/sa_sequencer.sv
source/sa_top.sv
tb/tb_sa_top.sv

// File: source/sa_apb_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "sa_config.svh"

module sa_apb_port (
    input  wire logic             clk,
    input  wire logic             i_rst_n,
    input  wire sa_pkg::apb_req_t i_apb,
    output sa_pkg::apb_rsp_t      o_apb,
    output sa_pkg::buf_req_t      o_buf_req,
    input  wire logic             i_buf_gnt,
    input  wire sa_pkg::sa_word_t i_buf_rdata,
    input  wire logic             i_busy,
    input  wire logic             i_done,
    output logic                  o_start
);

    sa_pkg::sa_addr_u addr;
    logic             access;   // apb access phase
    logic             is_reg;
    logic             rd_pend;  // read granted last cycle, data is on i_buf_rdata

    assign addr   = i_apb.paddr[7:2];
    assign access = i_apb.psel && i_apb.penable;
    assign is_reg = (addr.f.region == `SA_MAT_REG);

    // start only counts while the engine is idle
    assign o_start = access && is_reg && i_apb.pwrite && (addr.f.col == `SA_REG_CTRL)
                     && i_apb.pwdata[0] && !i_busy;

    always_comb begin
        o_apb           = '0;
        o_buf_req       = '0;
        o_buf_req.we    = i_apb.pwrite;
        o_buf_req.addr  = addr;
        o_buf_req.wdata = i_apb.pwdata[`SA_DW-1:0];

        if (rd_pend) begin
            o_apb.pready = 1'b1;
            o_apb.prdata = {{(32-`SA_DW){1'b0}}, i_buf_rdata};
        end else if (access && is_reg) begin
            o_apb.pready = 1'b1;  // registers never wait
            case (addr.f.col)
                `SA_REG_CTRL:   o_apb.prdata = '0;
                `SA_REG_STATUS: o_apb.prdata = {30'd0, i_done, i_busy};
                default:        o_apb.pslverr = 1'b1;
            endcase
        end else if (access) begin
            // held until the sequencer lets go of the buffer
            o_buf_req.valid = 1'b1;
            o_apb.pready    = i_buf_gnt && i_apb.pwrite;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= !rd_pend && access && !is_reg && !i_apb.pwrite && i_buf_gnt;
        end
    end

endmodule

`default_nettype wire

// File: source/sa_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "sa_config.svh"

module sa_array (
    input  wire logic             clk,
    input  wire logic             i_rst_n,
    input  wire logic             i_clear,
    input  wire logic             i_step,
    input  wire logic             i_drain,
    input  wire sa_pkg::sa_word_t i_west_col [`SA_N],
    input  wire sa_pkg::sa_word_t i_north_row [`SA_N],
    output sa_pkg::sa_word_t      o_result_col [`SA_N]
);

    // one extra column / row so the edges fit the same indexing
    wire sa_pkg::sa_word_t east_w  [`SA_N][`SA_N+1];
    wire sa_pkg::sa_word_t south_w [`SA_N+1][`SA_N];
    wire sa_pkg::sa_word_t acc_w   [`SA_N][`SA_N+1];

    genvar r, c;
    generate
        for (r = 0; r < `SA_N; r++) begin : g_edge
            assign east_w[r][0]     = i_west_col[r];
            assign south_w[0][r]    = i_north_row[r];
            assign acc_w[r][`SA_N]  = '0;  // zeros enter from the east on drain
            assign o_result_col[r]  = acc_w[r][0];
        end

        for (r = 0; r < `SA_N; r++) begin : g_row
            for (c = 0; c < `SA_N; c++) begin : g_col
                sa_pe sa_pe_i (
                    .clk        (clk),
                    .i_rst_n    (i_rst_n),
                    .i_clear    (i_clear),
                    .i_step     (i_step),
                    .i_drain    (i_drain),
                    .i_west     (east_w[r][c]),
                    .i_north    (south_w[r][c]),
                    .i_east_acc (acc_w[r][c+1]),
                    .o_east     (east_w[r][c+1]),
                    .o_south    (south_w[r+1][c]),
                    .o_acc      (acc_w[r][c])
                );
            end
        end
    endgenerate

endmodule

`default_nettype wire

// File: source/sa_config.svh
`ifndef SA_CONFIG_SVH
`define SA_CONFIG_SVH

// grid and word sizes
`define SA_N        4
`define SA_IDX_W    2
`define SA_DW       16
`define SA_ADDR_W   6

// region codes, top bits of the word address
`define SA_MAT_A    2'd0
`define SA_MAT_B    2'd1
`define SA_MAT_C    2'd2
`define SA_MAT_REG  2'd3

// column index inside the register region
`define SA_REG_CTRL   2'd0
`define SA_REG_STATUS 2'd1

`endif

// File: source/sa_pe.sv
`timescale 1ns/1ps
`default_nettype none

module sa_pe (
    input  wire logic             clk,
    input  wire logic             i_rst_n,
    input  wire logic             i_clear,
    input  wire logic             i_step,
    input  wire logic             i_drain,
    input  wire sa_pkg::sa_word_t i_west,
    input  wire sa_pkg::sa_word_t i_north,
    input  wire sa_pkg::sa_word_t i_east_acc,
    output sa_pkg::sa_word_t      o_east,
    output sa_pkg::sa_word_t      o_south,
    output sa_pkg::sa_word_t      o_acc
);

    // clear wins over drain, drain over step
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_acc   <= '0;
            o_east  <= '0;
            o_south <= '0;
        end else if (i_clear) begin
            o_acc   <= '0;
            o_east  <= '0;  // drop operands left over from the last run
            o_south <= '0;
        end else if (i_drain) begin
            o_acc <= i_east_acc;  // results move one place west
        end else if (i_step) begin
            o_acc   <= o_acc + i_west * i_north;  // wraps mod 2^16
            o_east  <= i_west;
            o_south <= i_north;
        end
    end

endmodule

`default_nettype wire

// File: source/sa_pkg.sv
`default_nettype none

`include "sa_config.svh"

package sa_pkg;

    typedef logic [`SA_DW-1:0] sa_word_t;

    // region / row / column view of a word address
    typedef struct packed {
        logic [`SA_ADDR_W-2*`SA_IDX_W-1:0] region;
        logic [`SA_IDX_W-1:0]              row;
        logic [`SA_IDX_W-1:0]              col;
    } sa_addr_f_t;

    // same word address, flat view indexes the buffer
    typedef union packed {
        logic [`SA_ADDR_W-1:0] flat;
        sa_addr_f_t            f;
    } sa_addr_u;

    typedef struct packed {
        logic     valid;
        logic     we;
        sa_addr_u addr;
        sa_word_t wdata;
    } buf_req_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;     // word index in [7:2]
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

// File: source/sa_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "sa_config.svh"

module sa_sequencer (
    input  wire logic             clk,
    input  wire logic             i_rst_n,
    input  wire logic             i_start,
    output logic                  o_busy,
    output logic                  o_done,
    output sa_pkg::buf_req_t      o_buf_req,
    input  wire logic             i_buf_gnt,
    input  wire sa_pkg::sa_word_t i_buf_rdata,
    output logic                  o_clear,
    output logic                  o_step,
    output logic                  o_drain,
    output sa_pkg::sa_word_t      o_west_col [`SA_N],
    output sa_pkg::sa_word_t      o_north_row [`SA_N],
    input  wire sa_pkg::sa_word_t i_result_col [`SA_N]
);

    localparam int T_W    = $clog2(3 * `SA_N - 2);
    localparam int SLOT_W = `SA_IDX_W + 1;  // slots 0..N-1 are rows of a, N..2N-1 columns of b

    localparam logic [T_W-1:0]    LAST_T    = T_W'(3 * `SA_N - 3);
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(2 * `SA_N - 1);
    localparam logic [SLOT_W-1:0] LAST_ROW  = SLOT_W'(`SA_N - 1);
    localparam logic [`SA_IDX_W-1:0] LAST_COL = `SA_IDX_W'(`SA_N - 1);

    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_CLEAR = 3'd1;
    localparam logic [2:0] ST_FETCH = 3'd2;
    localparam logic [2:0] ST_CAPT  = 3'd3;
    localparam logic [2:0] ST_STEP  = 3'd4;
    localparam logic [2:0] ST_WRITE = 3'd5;
    localparam logic [2:0] ST_DRAIN = 3'd6;

    logic [2:0]           state;
    logic [T_W-1:0]       t;     // wavefront step
    logic [SLOT_W-1:0]    k;     // staging slot, or c row while writing
    logic [`SA_IDX_W-1:0] s;     // drained column
    logic                 done_q;

    logic                 is_b;
    logic [`SA_IDX_W-1:0] idx;
    logic [T_W:0]         diff;  // t minus idx, msb set when negative
    logic                 in_range;

    sa_pkg::sa_word_t stage [2*`SA_N];

    assign is_b     = k[`SA_IDX_W];
    assign idx      = k[`SA_IDX_W-1:0];
    assign diff     = {1'b0, t} - (T_W+1)'(idx);
    assign in_range = !diff[T_W] && (diff < (T_W+1)'(`SA_N));

    assign o_busy  = (state != ST_IDLE);
    assign o_done  = done_q;
    assign o_clear = (state == ST_CLEAR);
    assign o_step  = (state == ST_STEP);
    assign o_drain = (state == ST_DRAIN);

    always_comb begin
        for (int i = 0; i < `SA_N; i++) begin
            o_west_col[i]  = stage[i];
            o_north_row[i] = stage[`SA_N+i];
        end
    end

    always_comb begin
        o_buf_req = '0;
        if (state == ST_FETCH) begin
            o_buf_req.valid         = in_range;  // out of range words are never read
            o_buf_req.addr.f.region = is_b ? `SA_MAT_B : `SA_MAT_A;
            o_buf_req.addr.f.row    = is_b ? diff[`SA_IDX_W-1:0] : idx;
            o_buf_req.addr.f.col    = is_b ? idx : diff[`SA_IDX_W-1:0];
        end else if (state == ST_WRITE) begin
            o_buf_req.valid         = 1'b1;
            o_buf_req.we            = 1'b1;
            o_buf_req.addr.f.region = `SA_MAT_C;
            o_buf_req.addr.f.row    = idx;
            o_buf_req.addr.f.col    = s;
            o_buf_req.wdata         = i_result_col[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_CAPT) begin
            stage[k] <= i_buf_rdata;
        end else if (state == ST_FETCH && !in_range) begin
            stage[k] <= '0;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state  <= ST_IDLE;
            t      <= '0;
            k      <= '0;
            s      <= '0;
            done_q <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_start) begin
                        state  <= ST_CLEAR;
                        done_q <= 1'b0;
                    end
                end
                ST_CLEAR: begin
                    t     <= '0;
                    k     <= '0;
                    state <= ST_FETCH;
                end
                ST_FETCH: begin
                    if (!in_range) begin
                        k <= k + 1'b1;
                        if (k == LAST_SLOT) state <= ST_STEP;
                    end else if (i_buf_gnt) begin
                        state <= ST_CAPT;
                    end
                end
                ST_CAPT: begin
                    k     <= k + 1'b1;
                    state <= (k == LAST_SLOT) ? ST_STEP : ST_FETCH;
                end
                ST_STEP: begin
                    k <= '0;
                    t <= t + 1'b1;
                    if (t == LAST_T) begin
                        s     <= '0;
                        state <= ST_WRITE;
                    end else begin
                        state <= ST_FETCH;
                    end
                end
                ST_WRITE: begin
                    if (i_buf_gnt) begin
                        k <= k + 1'b1;
                        if (k == LAST_ROW) state <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    k <= '0;
                    s <= s + 1'b1;
                    if (s == LAST_COL) begin
                        state  <= ST_IDLE;
                        done_q <= 1'b1;
                    end else begin
                        state <= ST_WRITE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/sa_shared_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "sa_config.svh"

module sa_shared_buffer (
    input  wire logic             clk,
    input  wire logic             i_rst_n,
    input  wire sa_pkg::buf_req_t i_seq_req,
    input  wire sa_pkg::buf_req_t i_host_req,
    output logic                  o_seq_gnt,
    output logic                  o_host_gnt,
    output sa_pkg::sa_word_t      o_rdata
);

    localparam int DEPTH = 3 * `SA_N * `SA_N;  // matrices a, b and c

    sa_pkg::sa_word_t mem [DEPTH];
    sa_pkg::buf_req_t req;
    logic             hit;

    // sequencer always wins, host gets the leftover cycles
    assign o_seq_gnt  = i_seq_req.valid;
    assign o_host_gnt = i_host_req.valid && !i_seq_req.valid;

    assign req = i_seq_req.valid ? i_seq_req : i_host_req;
    assign hit = req.valid && (req.addr.f.region != `SA_MAT_REG);

    always_ff @(posedge clk) begin
        if (hit && req.we) begin
            mem[req.addr.flat] <= req.wdata;
        end
    end

    // read data lands one cycle after the grant
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rdata <= '0;
        end else if (hit && !req.we) begin
            o_rdata <= mem[req.addr.flat];
        end
    end

endmodule

`default_nettype wire

// File: source/sa_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "sa_config.svh"

module sa_top (
    input  wire logic             clk,
    input  wire logic             i_rst_n,
    input  wire sa_pkg::apb_req_t i_apb,
    output wire sa_pkg::apb_rsp_t o_apb,
    output wire logic             o_done
);

    wire sa_pkg::buf_req_t seq_req;
    wire sa_pkg::buf_req_t host_req;
    wire logic             seq_gnt;
    wire logic             host_gnt;
    wire sa_pkg::sa_word_t buf_rdata;
    wire logic             busy;
    wire logic             start;
    wire logic             clear;
    wire logic             step;
    wire logic             drain;
    wire sa_pkg::sa_word_t west_col [`SA_N];
    wire sa_pkg::sa_word_t north_row [`SA_N];
    wire sa_pkg::sa_word_t result_col [`SA_N];

    sa_apb_port sa_apb_port_i (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_apb       (i_apb),
        .o_apb       (o_apb),
        .o_buf_req   (host_req),
        .i_buf_gnt   (host_gnt),
        .i_buf_rdata (buf_rdata),
        .i_busy      (busy),
        .i_done      (o_done),
        .o_start     (start)
    );

    sa_sequencer sa_sequencer_i (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_start      (start),
        .o_busy       (busy),
        .o_done       (o_done),
        .o_buf_req    (seq_req),
        .i_buf_gnt    (seq_gnt),
        .i_buf_rdata  (buf_rdata),
        .o_clear      (clear),
        .o_step       (step),
        .o_drain      (drain),
        .o_west_col   (west_col),
        .o_north_row  (north_row),
        .i_result_col (result_col)
    );

    sa_shared_buffer sa_shared_buffer_i (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_seq_req  (seq_req),
        .i_host_req (host_req),
        .o_seq_gnt  (seq_gnt),
        .o_host_gnt (host_gnt),
        .o_rdata    (buf_rdata)
    );

    sa_array sa_array_i (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_clear      (clear),
        .i_step       (step),
        .i_drain      (drain),
        .i_west_col   (west_col),
        .i_north_row  (north_row),
        .o_result_col (result_col)
    );

endmodule

`default_nettype wire

// File: tb/tb_sa_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "sa_config.svh"

module tb_sa_top;

    localparam int CLK_PERIOD  = 40;
    localparam int APB_TIMEOUT = 100;   // cycles per apb transfer
    localparam int RUN_TIMEOUT = 2000;  // cycles from start to done

    logic             clk;
    logic             rst_n;
    sa_pkg::apb_req_t apb_req;
    wire sa_pkg::apb_rsp_t apb_rsp;
    wire logic        done;

    logic [31:0] lfsr;
    logic [15:0] mat_a [`SA_N][`SA_N];  // host copy of the operands
    logic [15:0] mat_b [`SA_N][`SA_N];
    int          checks;
    int          errors;
    int          timeouts;

    sa_top sa_top_i (
        .clk     (clk),
        .i_rst_n (rst_n),
        .i_apb   (apb_req),
        .o_apb   (apb_rsp),
        .o_done  (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // galois lfsr, one step per bit
    function automatic logic rand_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) lfsr = lfsr ^ 32'h80200003;
        return b;
    endfunction

    function automatic logic [15:0] rand_word();
        logic [15:0] w;
        w = '0;
        for (int n = 0; n < 16; n++) w = {w[14:0], rand_bit()};
        return w;
    endfunction

    // one element of a x b, wraps mod 2^16
    function automatic logic [15:0] model_c(input int row, input int col);
        logic [15:0] acc;
        acc = '0;
        for (int k = 0; k < `SA_N; k++) acc = acc + mat_a[row][k] * mat_b[k][col];
        return acc;
    endfunction

    function automatic logic [7:0] word_addr(input logic [1:0] region, input int row,
                                             input int col);
        logic [1:0] r;
        logic [1:0] c;
        r = row[1:0];
        c = col[1:0];
        return {region, r, c, 2'b00};  // byte address, word index in [7:2]
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
        end
    endtask

    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int waits;
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        #(CLK_PERIOD/4);
        checks++;
        assert (!apb_rsp.pready) else begin
            errors++;
            $display("pready went high in the setup phase at time %0t", $time);
        end
        @(negedge clk);
        apb_req.penable = 1'b1;
        waits = 0;
        #(CLK_PERIOD/4);  // sample well away from either edge
        while (!apb_rsp.pready && waits < APB_TIMEOUT) begin
            @(negedge clk);
            #(CLK_PERIOD/4);
            waits++;
        end
        if (!apb_rsp.pready) begin
            timeouts++;
            $display("APB transfer to address %h never saw pready at time %0t", addr, $time);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        logic        err;
        apb_access(1'b1, addr, data, unused, err);
        check_value($sformatf("pslverr on write %h", addr), err, 0);
    endtask

    task automatic expect_read(input logic [7:0] addr, input logic [31:0] exp,
                               input string name);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b0, addr, '0, rd, err);
        check_value(name, rd, exp);
        check_value({name, " pslverr"}, err, 0);
    endtask

    task automatic load_operands();
        for (int i = 0; i < `SA_N; i++) begin
            for (int j = 0; j < `SA_N; j++) begin
                mat_a[i][j] = rand_word();
                mat_b[i][j] = rand_word();
                // upper half is junk, the buffer keeps only 16 bits
                apb_write(word_addr(`SA_MAT_A, i, j), {~mat_a[i][j], mat_a[i][j]});
                apb_write(word_addr(`SA_MAT_B, i, j), {~mat_b[i][j], mat_b[i][j]});
            end
        end
    endtask

    task automatic readback_operands();
        for (int i = 0; i < `SA_N; i++) begin
            for (int j = 0; j < `SA_N; j++) begin
                expect_read(word_addr(`SA_MAT_A, i, j), {16'h0, mat_a[i][j]},
                            $sformatf("A[%0d][%0d]", i, j));
                expect_read(word_addr(`SA_MAT_B, i, j), {16'h0, mat_b[i][j]},
                            $sformatf("B[%0d][%0d]", i, j));
            end
        end
    endtask

    task automatic run_engine();
        int waits;
        apb_write(word_addr(`SA_MAT_REG, 0, `SA_REG_CTRL), 32'h1);
        check_value("o_done after start", done, 0);
        expect_read(word_addr(`SA_MAT_REG, 0, `SA_REG_STATUS), 32'h1, "status while busy");

        // host reads compete with sequencer fetches
        for (int i = 0; i < `SA_N; i++) begin
            for (int j = 0; j < `SA_N; j++) begin
                expect_read(word_addr(`SA_MAT_A, i, j), {16'h0, mat_a[i][j]},
                            $sformatf("A[%0d][%0d] during run", i, j));
            end
        end

        waits = 0;
        while (!done && waits < RUN_TIMEOUT) begin
            @(negedge clk);
            waits++;
        end
        if (!done) begin
            timeouts++;
            $display("engine did not raise o_done within %0d cycles", RUN_TIMEOUT);
        end
        expect_read(word_addr(`SA_MAT_REG, 0, `SA_REG_STATUS), 32'h2, "status after run");

        for (int i = 0; i < `SA_N; i++) begin
            for (int j = 0; j < `SA_N; j++) begin
                expect_read(word_addr(`SA_MAT_C, i, j), {16'h0, model_c(i, j)},
                            $sformatf("C[%0d][%0d]", i, j));
            end
        end
    endtask

    initial begin
        logic [31:0] rd;
        logic        err;
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        lfsr     = 32'h1d3c969d;
        rst_n    = 1'b0;
        apb_req  = '0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #(CLK_PERIOD/4);
        check_value("o_done after reset", done, 0);
        check_value("pready after reset", apb_rsp.pready, 0);
        check_value("pslverr after reset", apb_rsp.pslverr, 0);
        expect_read(word_addr(`SA_MAT_REG, 0, `SA_REG_STATUS), 32'h0, "status after reset");

        load_operands();
        readback_operands();
        run_engine();

        // column 2 of the register region is unmapped
        apb_access(1'b0, word_addr(`SA_MAT_REG, 0, 2), '0, rd, err);
        check_value("pslverr on register column 2", err, 1);

        // fresh operands, c must not carry the first result
        load_operands();
        run_engine();

        $display("checks=%0d errors=%0d timeouts=%0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
